//--- spw_tx_pkg.sv
//----------------------------------------
// Shared types and constants of the SpaceWire transmitter.
// Referenced by scoped names from every RTL file.
//----------------------------------------

package spw_tx_pkg;

	//----------------------------------------
	// Character kinds
	//----------------------------------------

	typedef enum logic [2:0]
	{
		kind_null = 3'd0,
		kind_fct  = 3'd1,
		kind_data = 3'd2,
		kind_eop  = 3'd3,
		kind_eep  = 3'd4
	} char_kind_e;

	// Data byte is only meaningful for kind_data
	typedef struct packed
	{
		char_kind_e  kind;
		logic [7:0]  data;
	} tx_char_t;

	//----------------------------------------
	// Control codes sent bit 1 first
	//----------------------------------------

	localparam logic [1:0] code_fct = 2'b00;
	localparam logic [1:0] code_eop = 2'b01;
	localparam logic [1:0] code_eep = 2'b10;
	localparam logic [1:0] code_esc = 2'b11;

	// Character lengths in bits
	localparam logic [3:0] len_null    = 4'd8;
	localparam logic [3:0] len_fct     = 4'd4;
	localparam logic [3:0] len_eop_eep = 4'd4;
	localparam logic [3:0] len_data    = 4'd10;

	//----------------------------------------
	// Flow control
	//----------------------------------------

	typedef logic [5:0] credit_t;

	localparam credit_t credit_per_fct = 6'd8;
	localparam credit_t credit_max     = 6'd56;

	// FCTs still to be sent to the far end
	typedef logic [2:0] fct_owed_t;

	localparam fct_owed_t fct_owed_init = 3'd7;
	localparam fct_owed_t fct_owed_max  = 3'd7;

endpackage

//--- spw_tx_buffer.sv
//----------------------------------------
// Host side holding register for one character.
// Loaded by txwrite_tx, emptied by the scheduler's take.
//----------------------------------------

module spw_tx_buffer (
	input  logic                  pclk_tx,
	input  logic                  enable_tx,
	input  logic [8:0]            data_tx_i,
	input  logic                  txwrite_tx,
	input  logic                  char_take,
	output logic                  buf_valid,
	output spw_tx_pkg::tx_char_t  buf_char,
	output logic                  ready_tx_data
);

	spw_tx_pkg::tx_char_t wr_char;

	// Bit 8 marks an end of packet, bit 0 picks EEP over EOP
	always_comb
	begin
		wr_char.data = data_tx_i[7:0];
		if (!data_tx_i[8])
			wr_char.kind = spw_tx_pkg::kind_data;
		else if (data_tx_i[0])
			wr_char.kind = spw_tx_pkg::kind_eep;
		else
			wr_char.kind = spw_tx_pkg::kind_eop;
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			buf_valid     <= 1'b0;
			ready_tx_data <= 1'b0;
		end
		else
		begin
			ready_tx_data <= char_take;
			if (char_take)
				buf_valid <= 1'b0;
			else if (txwrite_tx)
				buf_valid <= 1'b1;
		end
	end

	// Writes into a full buffer are dropped
	always_ff @(posedge pclk_tx)
	begin
		if (txwrite_tx && !buf_valid)
			buf_char <= wr_char;
	end

	a_take_needs_valid: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		char_take |-> buf_valid);

endmodule

//--- spw_tx_credit.sv
//----------------------------------------
// Transmit credit and owed FCT counters.
// Both saturate, credit starts empty, owed FCTs start full.
//----------------------------------------

module spw_tx_credit (
	input  logic                   pclk_tx,
	input  logic                   enable_tx,
	input  logic                   gotfct_tx,
	input  logic                   send_fct_now,
	input  logic                   n_sent,
	input  logic                   fct_sent,
	output spw_tx_pkg::credit_t    credit,
	output spw_tx_pkg::fct_owed_t  fct_owed
);

	logic [6:0]             credit_sum;
	logic [3:0]             owed_sum;
	spw_tx_pkg::credit_t    credit_next;
	spw_tx_pkg::fct_owed_t  owed_next;

	//----------------------------------------
	// Credit counter
	//----------------------------------------

	always_comb
	begin
		credit_sum = {1'b0, credit};
		if (gotfct_tx)
			credit_sum = credit_sum + {1'b0, spw_tx_pkg::credit_per_fct};
		if (n_sent)
			credit_sum = credit_sum - 7'd1;
		if (credit_sum > {1'b0, spw_tx_pkg::credit_max})
			credit_next = spw_tx_pkg::credit_max;
		else
			credit_next = credit_sum[5:0];
	end

	//----------------------------------------
	// FCTs owed to the far end
	//----------------------------------------

	always_comb
	begin
		owed_sum = {1'b0, fct_owed};
		if (send_fct_now)
			owed_sum = owed_sum + 4'd1;
		if (fct_sent)
			owed_sum = owed_sum - 4'd1;
		if (owed_sum > {1'b0, spw_tx_pkg::fct_owed_max})
			owed_next = spw_tx_pkg::fct_owed_max;
		else
			owed_next = owed_sum[2:0];
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit   <= '0;
			fct_owed <= spw_tx_pkg::fct_owed_init;
		end
		else
		begin
			credit   <= credit_next;
			fct_owed <= owed_next;
		end
	end

	// Far end never over-grants and credit never underflows
	a_credit_max: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		credit_sum <= {1'b0, spw_tx_pkg::credit_max});

	// An FCT is only chosen while one is owed
	a_owed_no_wrap: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		fct_sent |-> fct_owed != '0);

endmodule

//--- spw_tx_scheduler.sv
//----------------------------------------
// Link start-up and choice of the next character.
// next_char is sampled by the encoder on next_req.
//----------------------------------------

module spw_tx_scheduler (
	input  logic                   pclk_tx,
	input  logic                   enable_tx,
	input  logic                   send_null_tx,
	input  logic                   send_fct_tx,
	input  logic                   next_req,
	input  logic                   buf_valid,
	input  spw_tx_pkg::tx_char_t   buf_char,
	input  spw_tx_pkg::credit_t    credit,
	input  spw_tx_pkg::fct_owed_t  fct_owed,
	output spw_tx_pkg::tx_char_t   next_char,
	output logic                   line_active,
	output logic                   char_take,
	output logic                   n_sent,
	output logic                   fct_sent
);

	typedef enum logic [1:0]
	{
		link_start     = 2'd0,
		link_null_only = 2'd1,
		link_run       = 2'd2
	} link_state_e;

	link_state_e link_state;
	logic        go_run;
	logic        run_sel;
	logic        pick_fct;
	logic        pick_buf;

	// Entering run takes effect at the boundary, so that choice already uses run priority
	assign go_run   = (link_state == link_null_only) && send_null_tx && send_fct_tx;
	assign run_sel  = (link_state == link_run) || go_run;
	assign pick_fct = run_sel && (fct_owed != '0);
	assign pick_buf = run_sel && !pick_fct && buf_valid && (credit != '0);

	always_comb
	begin
		next_char.kind = spw_tx_pkg::kind_null;
		next_char.data = 8'h00;
		if (pick_fct)
			next_char.kind = spw_tx_pkg::kind_fct;
		else if (pick_buf)
			next_char = buf_char;
	end

	assign line_active = (link_state != link_start);
	assign char_take   = next_req && pick_buf;
	assign fct_sent    = next_req && pick_fct;
	assign n_sent      = char_take && (buf_char.kind != spw_tx_pkg::kind_null)
		&& (buf_char.kind != spw_tx_pkg::kind_fct);

	//----------------------------------------
	// Start-up state
	//----------------------------------------

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			link_state <= link_start;
		else
		begin
			case (link_state)
				link_start:
				begin
					if (send_null_tx)
						link_state <= link_null_only;
				end
				link_null_only:
				begin
					if (go_run && next_req)
						link_state <= link_run;
				end
				default:
				begin
					link_state <= link_run;
				end
			endcase
		end
	end

	// The encoder stays idle until the link leaves start
	a_no_req_at_start: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		next_req |-> link_state != link_start);

endmodule

//--- spw_tx_encoder.sv
//----------------------------------------
// Serialiser with parity and data-strobe coding.
// One bit per clock, lines delayed by two registers.
//----------------------------------------

module spw_tx_encoder (
	input  logic                  pclk_tx,
	input  logic                  enable_tx,
	input  logic                  line_active,
	input  spw_tx_pkg::tx_char_t  next_char,
	output logic                  next_req,
	output logic                  tx_dout_e,
	output logic                  tx_sout_e
);

	logic [9:0] shreg;
	logic [3:0] bits_left;
	logic       tail_par;
	logic [9:0] load_word;
	logic [3:0] load_len;
	logic       load_tail;
	logic [1:0] ctrl_code;
	logic       cur_bit;
	logic       bit_out;
	logic       strobe;
	logic       last_dout;
	logic       last_sout;

	//----------------------------------------
	// Character build with bit 0 first
	//----------------------------------------

	// Parity is ~(tail ^ flag), so tail_par for control chars and its inverse for data
	always_comb
	begin
		ctrl_code = spw_tx_pkg::code_fct;
		if (next_char.kind == spw_tx_pkg::kind_eop)
			ctrl_code = spw_tx_pkg::code_eop;
		else if (next_char.kind == spw_tx_pkg::kind_eep)
			ctrl_code = spw_tx_pkg::code_eep;

		case (next_char.kind)
			spw_tx_pkg::kind_data:
			begin
				load_word = {next_char.data, 1'b0, ~tail_par};
				load_len  = spw_tx_pkg::len_data;
				load_tail = ^next_char.data;
			end
			spw_tx_pkg::kind_fct:
			begin
				load_word = {6'd0, ctrl_code[0], ctrl_code[1], 1'b1, tail_par};
				load_len  = spw_tx_pkg::len_fct;
				load_tail = ^ctrl_code;
			end
			spw_tx_pkg::kind_eop, spw_tx_pkg::kind_eep:
			begin
				load_word = {6'd0, ctrl_code[0], ctrl_code[1], 1'b1, tail_par};
				load_len  = spw_tx_pkg::len_eop_eep;
				load_tail = ^ctrl_code;
			end
			default:
			begin
				// ESC then FCT with its inner parity at 0
				load_word = {2'b00, spw_tx_pkg::code_fct[0], spw_tx_pkg::code_fct[1],
					1'b1, 1'b0, spw_tx_pkg::code_esc[0], spw_tx_pkg::code_esc[1],
					1'b1, tail_par};
				load_len  = spw_tx_pkg::len_null;
				load_tail = ^spw_tx_pkg::code_fct;
			end
		endcase
	end

	// Also requests the first character while idle
	assign next_req = line_active && (bits_left <= 4'd1);
	assign bit_out  = (bits_left != 4'd0);
	assign cur_bit  = shreg[0];
	assign strobe   = (cur_bit == last_dout) ? ~last_sout : last_sout;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			bits_left <= 4'd0;
			tail_par  <= 1'b0;
		end
		else if (next_req)
		begin
			bits_left <= load_len;
			tail_par  <= load_tail;
		end
		else if (bit_out)
			bits_left <= bits_left - 4'd1;
	end

	always_ff @(posedge pclk_tx)
	begin
		if (next_req)
			shreg <= load_word;
		else
			shreg <= {1'b0, shreg[9:1]};
	end

	//----------------------------------------
	// Line registers
	//----------------------------------------

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			last_dout <= 1'b0;
			last_sout <= 1'b0;
			tx_dout_e <= 1'b0;
			tx_sout_e <= 1'b0;
		end
		else
		begin
			if (bit_out)
			begin
				last_dout <= cur_bit;
				last_sout <= strobe;
			end
			tx_dout_e <= last_dout;
			tx_sout_e <= last_sout;
		end
	end

	a_ds_one_change: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!($changed(tx_dout_e) && $changed(tx_sout_e)));

endmodule

//--- spw_tx_top.sv
//----------------------------------------
// SpaceWire transmitter top level.
//----------------------------------------

module spw_tx_top (
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic [8:0] data_tx_i,
	input  logic       txwrite_tx,
	input  logic       send_null_tx,
	input  logic       send_fct_tx,
	input  logic       gotfct_tx,
	input  logic       send_fct_now,
	output logic       tx_dout_e,
	output logic       tx_sout_e,
	output logic       ready_tx_data
);

	logic                   buf_valid;
	spw_tx_pkg::tx_char_t   buf_char;
	spw_tx_pkg::tx_char_t   next_char;
	logic                   char_take;
	logic                   next_req;
	logic                   line_active;
	logic                   n_sent;
	logic                   fct_sent;
	spw_tx_pkg::credit_t    credit;
	spw_tx_pkg::fct_owed_t  fct_owed;

	spw_tx_buffer i_buffer (
		.pclk_tx       (pclk_tx),
		.enable_tx     (enable_tx),
		.data_tx_i     (data_tx_i),
		.txwrite_tx    (txwrite_tx),
		.char_take     (char_take),
		.buf_valid     (buf_valid),
		.buf_char      (buf_char),
		.ready_tx_data (ready_tx_data)
	);

	spw_tx_credit i_credit (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.gotfct_tx    (gotfct_tx),
		.send_fct_now (send_fct_now),
		.n_sent       (n_sent),
		.fct_sent     (fct_sent),
		.credit       (credit),
		.fct_owed     (fct_owed)
	);

	spw_tx_scheduler i_scheduler (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.send_null_tx (send_null_tx),
		.send_fct_tx  (send_fct_tx),
		.next_req     (next_req),
		.buf_valid    (buf_valid),
		.buf_char     (buf_char),
		.credit       (credit),
		.fct_owed     (fct_owed),
		.next_char    (next_char),
		.line_active  (line_active),
		.char_take    (char_take),
		.n_sent       (n_sent),
		.fct_sent     (fct_sent)
	);

	spw_tx_encoder i_encoder (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.line_active (line_active),
		.next_char   (next_char),
		.next_req    (next_req),
		.tx_dout_e   (tx_dout_e),
		.tx_sout_e   (tx_sout_e)
	);

endmodule

//--- tb_spw_tx.sv
//----------------------------------------
// Random traffic testbench for the SpaceWire transmitter.
// Decodes the DS lines and checks them against a model.
//----------------------------------------

module tb_spw_tx;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_words     = 200;
	localparam int credit_step = 8;
	localparam int fct_initial = 7;
	// About 100 cycles per word covers gaps, NULL waits and credit stalls
	localparam int max_cycles  = n_words * 100;

	logic       pclk_tx;
	logic       enable_tx;
	logic [8:0] data_tx_i;
	logic       txwrite_tx;
	logic       send_null_tx;
	logic       send_fct_tx;
	logic       gotfct_tx;
	logic       send_fct_now;
	logic       tx_dout_e;
	logic       tx_sout_e;
	logic       ready_tx_data;

	logic [31:0]           lfsr_state = 32'h37cf64ed;
	spw_tx_pkg::tx_char_t  exp_q[$];
	int                    cycle_count = 0;
	int                    wr_count = 0;
	int                    got_pulses = 0;
	int                    fct_pulses = 0;
	int                    n_decoded = 0;
	int                    fct_decoded = 0;
	int                    null_count = 0;
	logic                  ready_q = 1'b0;
	logic                  line_started = 1'b0;
	logic [1:0]            prev_pair = 2'b00;
	logic [9:0]            cbuf = '0;
	logic [3:0]            cnt = '0;
	logic                  prev_cov = 1'b0;

	spw_tx_top i_dut (
		.pclk_tx       (pclk_tx),
		.enable_tx     (enable_tx),
		.data_tx_i     (data_tx_i),
		.txwrite_tx    (txwrite_tx),
		.send_null_tx  (send_null_tx),
		.send_fct_tx   (send_fct_tx),
		.gotfct_tx     (gotfct_tx),
		.send_fct_now  (send_fct_now),
		.tx_dout_e     (tx_dout_e),
		.tx_sout_e     (tx_sout_e),
		.ready_tx_data (ready_tx_data)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever #20 pclk_tx = ~pclk_tx;
	end

	//----------------------------------------
	// Random source and result checks
	//----------------------------------------

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_char(input string name, input spw_tx_pkg::tx_char_t got,
		input spw_tx_pkg::tx_char_t exp);
		if (got !== exp)
			stop_with_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic compare_parity(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic compare_ds(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_with_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Builds a host word, 1 in 8 is an end of packet marker
	task automatic make_word(output logic [8:0] word, output spw_tx_pkg::tx_char_t exp_char);
		logic [31:0] r;
		draw_bits(3, r);
		exp_char.data = 8'h00;
		if (r[2:0] == 3'd0)
		begin
			draw_bits(1, r);
			word = {1'b1, 7'd0, r[0]};
			exp_char.kind = r[0] ? spw_tx_pkg::kind_eep : spw_tx_pkg::kind_eop;
		end
		else
		begin
			draw_bits(8, r);
			word = {1'b0, r[7:0]};
			exp_char.kind = spw_tx_pkg::kind_data;
			exp_char.data = r[7:0];
		end
	endtask

	//----------------------------------------
	// Line decoder
	//----------------------------------------

	task automatic finish_char(input spw_tx_pkg::tx_char_t got);
		spw_tx_pkg::tx_char_t exp_char;
		if (!send_fct_tx && got.kind != spw_tx_pkg::kind_null)
			stop_with_error("a character other than NULL was sent before send_fct_tx");
		case (got.kind)
			spw_tx_pkg::kind_null:
				null_count++;
			spw_tx_pkg::kind_fct:
				fct_decoded++;
			default:
			begin
				if (exp_q.size() == 0)
					stop_with_error("an N-character appeared that was never written");
				else
				begin
					exp_char = exp_q.pop_front();
					compare_char("n_char", got, exp_char);
				end
				n_decoded++;
				if (n_decoded > credit_step * got_pulses)
					stop_with_error("more N-characters were sent than credit was granted");
			end
		endcase
	endtask

	task automatic decode_bit(input logic b);
		spw_tx_pkg::tx_char_t got;
		logic [1:0]           code;
		cbuf[cnt] = b;
		cnt = cnt + 4'd1;
		got.kind = spw_tx_pkg::kind_null;
		got.data = 8'h00;
		code = {cbuf[2], cbuf[3]};
		if (cnt == 4'd2)
			compare_parity("parity", cbuf[0], ~(prev_cov ^ cbuf[1]));
		else if (cbuf[1] && cnt == 4'd4 && code != spw_tx_pkg::code_esc)
		begin
			if (code == spw_tx_pkg::code_fct)
				got.kind = spw_tx_pkg::kind_fct;
			else if (code == spw_tx_pkg::code_eop)
				got.kind = spw_tx_pkg::kind_eop;
			else
				got.kind = spw_tx_pkg::kind_eep;
			prev_cov = ^code;
			cnt = 4'd0;
			finish_char(got);
		end
		else if (cbuf[1] && cnt == 4'd6)
			compare_parity("null_parity", cbuf[4], ~((^spw_tx_pkg::code_esc) ^ cbuf[5]));
		else if (cbuf[1] && cnt == 4'd8)
		begin
			if (!cbuf[5] || {cbuf[6], cbuf[7]} != spw_tx_pkg::code_fct)
				stop_with_error("an ESC on the line was not followed by an FCT");
			prev_cov = ^spw_tx_pkg::code_fct;
			cnt = 4'd0;
			finish_char(got);
		end
		else if (!cbuf[1] && cnt == 4'd10)
		begin
			got.kind = spw_tx_pkg::kind_data;
			got.data = cbuf[9:2];
			prev_cov = ^cbuf[9:2];
			cnt = 4'd0;
			finish_char(got);
		end
	endtask

	always @(negedge pclk_tx)
	begin
		if (!send_null_tx)
		begin
			compare_ds("dout_sout", {tx_dout_e, tx_sout_e}, 2'b00);
			compare_count("ready_tx_data", int'(ready_tx_data), 0);
		end
		else if (line_started || {tx_dout_e, tx_sout_e} != prev_pair)
		begin
			line_started = 1'b1;
			// Strobe toggles only when the data bit repeats
			compare_ds("dout_sout", {tx_dout_e, tx_sout_e},
				{tx_dout_e, prev_pair[0] ^ (tx_dout_e == prev_pair[1])});
			decode_bit(tx_dout_e);
		end
		prev_pair = {tx_dout_e, tx_sout_e};
		ready_q   = ready_tx_data;
	end

	always @(posedge pclk_tx)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > max_cycles)
			stop_with_error($sformatf("timeout after %0d cycles, traffic did not finish",
				max_cycles));
	end

	//----------------------------------------
	// Stimulus
	//----------------------------------------

	initial
	begin
		logic [31:0]           r;
		logic [8:0]            word;
		spw_tx_pkg::tx_char_t  exp_char;
		int                    gap;
		int                    mark;
		logic                  wait_ready;
		enable_tx    = 1'b0;
		data_tx_i    = '0;
		txwrite_tx   = 1'b0;
		send_null_tx = 1'b0;
		send_fct_tx  = 1'b0;
		gotfct_tx    = 1'b0;
		send_fct_now = 1'b0;
		gap          = 0;
		wait_ready   = 1'b0;
		repeat (2) @(posedge pclk_tx);
		enable_tx <= 1'b1;
		repeat (3) @(posedge pclk_tx);
		send_null_tx <= 1'b1;
		while (null_count < 4)
			@(posedge pclk_tx);
		send_fct_tx <= 1'b1;

		while (wr_count < n_words || wait_ready)
		begin
			@(posedge pclk_tx);
			txwrite_tx   <= 1'b0;
			gotfct_tx    <= 1'b0;
			send_fct_now <= 1'b0;
			// Keep model credit and owed FCTs below their saturation points
			draw_bits(4, r);
			if (r[3:0] == 4'd0 && credit_step * got_pulses - n_decoded <= 40)
			begin
				gotfct_tx <= 1'b1;
				got_pulses++;
			end
			draw_bits(4, r);
			if (r[3:0] == 4'd0 && fct_initial + fct_pulses - fct_decoded <= 5)
			begin
				send_fct_now <= 1'b1;
				fct_pulses++;
			end
			if (wait_ready)
			begin
				if (ready_q)
				begin
					wait_ready = 1'b0;
					draw_bits(3, r);
					gap = int'(r[2:0]);
				end
			end
			else if (gap > 0)
				gap--;
			else
			begin
				make_word(word, exp_char);
				data_tx_i  <= word;
				txwrite_tx <= 1'b1;
				exp_q.push_back(exp_char);
				wr_count++;
				wait_ready = 1'b1;
			end
		end

		@(posedge pclk_tx);
		txwrite_tx   <= 1'b0;
		gotfct_tx    <= 1'b0;
		send_fct_now <= 1'b0;
		while (n_decoded < n_words || fct_decoded < fct_initial + fct_pulses)
			@(posedge pclk_tx);
		// A few trailing NULLs show no FCT is left over
		mark = null_count;
		while (null_count < mark + 4)
			@(posedge pclk_tx);
		compare_count("fct_count", fct_decoded, fct_initial + fct_pulses);
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- verilog.f
spw_tx_pkg.sv
spw_tx_buffer.sv
spw_tx_credit.sv
spw_tx_scheduler.sv
spw_tx_encoder.sv
spw_tx_top.sv
tb_spw_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SpaceWire transmitter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_spw_tx -f verilog.f -o Vtb_spw_tx

# The log decides the result, so a non-zero exit here is not fatal
./obj_dir/Vtb_spw_tx > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
